// File: uart_cmd_bridge.f
+incdir+common
common/uart_bridge_pkg.sv
uart/uart_tx_frame.sv
uart/uart_rx_frame.sv
source/uart_cmd_ctrl.sv
source/uart_cmd_bridge.sv
sim/tb_clk_gen.sv
sim/tb_uart_cmd_bridge.sv

// File: sim/tb_uart_cmd_bridge.sv
`default_nettype none
`timescale 1ns/100ps

`include "uart_bridge_config.svh"

module tb_uart_cmd_bridge
  import uart_bridge_pkg::*;
();

  localparam int BAUD_DIV     = `UART_BAUD_DIV;
  localparam int NUM_TESTS    = 9;
  localparam int ACCEPT_LIMIT = 100;
  localparam int FRAME_LIMIT  = 14 * BAUD_DIV;
  localparam int WRITE_LIMIT  = 30 * BAUD_DIV;
  localparam int RESULT_LIMIT = 40 * BAUD_DIV;
  localparam int IDLE_BITS    = 4;

  typedef enum int {RSP_GOOD, RSP_BAD_PARITY, RSP_BAD_STOP, RSP_NONE} rsp_mode_e;

  logic                       clk;
  logic                       rst_n;
  logic [`UART_CMD_WIDTH-1:0] cmd_in;
  logic                       cmd_vld;
  logic                       rx;
  logic                       tx;
  logic                       cmd_rdy;
  uart_byte_t                 read_data;
  logic                       read_rdy;
  logic                       read_err;

  string      cur_name;
  logic [9:0] frames [$];  // Stop, parity, data.
  string      t_name  [NUM_TESTS];
  logic [15:0] t_cmd  [NUM_TESTS];
  rsp_mode_e  t_mode  [NUM_TESTS];
  uart_byte_t t_rsp   [NUM_TESTS];
  logic       t_chain [NUM_TESTS];  // Hold t_next on cmd_vld during the first command.
  logic [15:0] t_next [NUM_TESTS];
  int         n_tests;
  logic [31:0] seed_ret;

  tb_clk_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(4)) clk_gen0 (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s: %s expected %0h actual %0h", name, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch.");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out in test %s while waiting for %s.", cur_name, what);
    $display("TEST FAILED");
    $fatal(1, "Timeout.");
  endtask

  task automatic add_entry(input string name, input logic [15:0] cmd, input rsp_mode_e mode,
                           input uart_byte_t rsp, input logic chain, input logic [15:0] next);
    t_name[n_tests]  = name;
    t_cmd[n_tests]   = cmd;
    t_mode[n_tests]  = mode;
    t_rsp[n_tests]   = rsp;
    t_chain[n_tests] = chain;
    t_next[n_tests]  = next;
    n_tests++;
  endtask

  function automatic logic [15:0] rand_cmd(input cmd_op_e op);
    logic [31:0] r;
    r = $urandom;
    return {op, r[14:8], r[7:0]};
  endfunction

  // Decodes frames on tx at bit centres.
  initial
  begin : tx_monitor
    logic [9:0] bits;
    int         k;
    forever
    begin
      @(negedge tx);
      repeat (BAUD_DIV / 2) @(negedge clk);
      check_value(cur_name, "tx start bit", 0, tx);
      for (k = 0; k < 10; k++)
      begin
        repeat (BAUD_DIV) @(negedge clk);
        bits[k] = tx;
      end
      frames.push_back(bits);
    end
  end

  task automatic send_cmd(input string name, input logic [15:0] cmd);
    int n;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    n = 0;
    while (!cmd_rdy && n < ACCEPT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
      report_timeout("cmd_rdy before command");
    @(negedge clk);
    check_value(name, "cmd_rdy after accept", 0, cmd_rdy);
    cmd_vld = 1'b0;
  endtask

  task automatic check_frame(input string name, input uart_byte_t payload);
    logic [9:0] f;
    int         n;
    n = 0;
    while (frames.size() == 0 && n < FRAME_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (frames.size() == 0)
      report_timeout("a frame on tx");
    f = frames.pop_front();
    check_value(name, "frame payload", payload, f[7:0]);
    check_value(name, "frame parity", ^payload, f[8]);  // Even parity.
    check_value(name, "frame stop bit", 1, f[9]);
  endtask

  task automatic drive_frame(input uart_byte_t data, input rsp_mode_e mode);
    logic [10:0] bits;
    int          k;
    bits[0]   = 1'b0;
    bits[8:1] = data;
    bits[9]   = (^data) ^ (mode == RSP_BAD_PARITY);
    bits[10]  = (mode != RSP_BAD_STOP);
    for (k = 0; k < 11; k++)
    begin
      rx = bits[k];
      repeat (BAUD_DIV) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic wait_result(input string name, input rsp_mode_e mode, input uart_byte_t rsp);
    int n;
    n = 0;
    while (!read_rdy && !read_err && n < RESULT_LIMIT)
    begin
      check_value(name, "cmd_rdy during read", 0, cmd_rdy);
      @(negedge clk);
      n++;
    end
    if (!read_rdy && !read_err)
      report_timeout("read_rdy or read_err");
    check_value(name, "read_rdy", mode == RSP_GOOD, read_rdy);
    check_value(name, "read_err", mode != RSP_GOOD, read_err);
    if (mode == RSP_GOOD)
      check_value(name, "read_data", rsp, read_data);
    @(negedge clk);
    check_value(name, "read_rdy width", 0, read_rdy);
    check_value(name, "read_err width", 0, read_err);
    check_value(name, "cmd_rdy after result", 1, cmd_rdy);
  endtask

  task automatic read_phase(input string name, input logic [15:0] cmd,
                            input rsp_mode_e mode, input uart_byte_t rsp);
    int delay;
    check_frame(name, {OP_READ, cmd[`UART_ADDR_MSB:`UART_ADDR_LSB]});
    delay = $urandom % (16 * BAUD_DIV);  // Well inside the response timeout.
    fork
      begin
        if (mode != RSP_NONE)
        begin
          repeat (delay) @(negedge clk);
          drive_frame(rsp, mode);
        end
      end
      wait_result(name, mode, rsp);
    join
  endtask

  task automatic write_phase(input string name, input logic [15:0] cmd);
    int n;
    n = 0;
    while (!cmd_rdy && n < WRITE_LIMIT)
    begin
      check_value(name, "read_rdy during write", 0, read_rdy);
      check_value(name, "read_err during write", 0, read_err);
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
      report_timeout("cmd_rdy after write");
    check_frame(name, {OP_WRITE, cmd[`UART_ADDR_MSB:`UART_ADDR_LSB]});
    check_frame(name, cmd[`UART_ADDR_LSB-1:0]);
  endtask

  task automatic idle_check(input string name);
    int k;
    for (k = 0; k < IDLE_BITS * BAUD_DIV; k++)
    begin
      @(negedge clk);
      check_value(name, "idle tx", 1, tx);
      check_value(name, "idle cmd_rdy", 1, cmd_rdy);
      check_value(name, "idle read_rdy", 0, read_rdy);
      check_value(name, "idle read_err", 0, read_err);
    end
    check_value(name, "extra frames", 0, frames.size());
  endtask

  initial
  begin : main
    int i;
    int n;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    n_tests  = 0;
    cur_name = "reset";
    seed_ret = $urandom(32'h9b66);

    add_entry("write_fixed", 16'hA53C, RSP_NONE, 8'h00, 1'b0, 16'h0000);
    add_entry("write_random", rand_cmd(OP_WRITE), RSP_NONE, 8'h00, 1'b0, 16'h0000);
    add_entry("read_good", 16'h1200, RSP_GOOD, 8'h5A, 1'b0, 16'h0000);
    add_entry("read_good_random", rand_cmd(OP_READ), RSP_GOOD, 8'($urandom), 1'b0, 16'h0000);
    add_entry("read_bad_parity", 16'h3300, RSP_BAD_PARITY, 8'hC3, 1'b0, 16'h0000);
    add_entry("read_bad_stop", 16'h4400, RSP_BAD_STOP, 8'h81, 1'b0, 16'h0000);
    add_entry("read_no_response", 16'h5500, RSP_NONE, 8'h00, 1'b0, 16'h0000);
    add_entry("write_after_timeout", rand_cmd(OP_WRITE), RSP_NONE, 8'h00, 1'b0, 16'h0000);
    add_entry("read_then_held_write", 16'h6600, RSP_GOOD, 8'h3E, 1'b1, rand_cmd(OP_WRITE));

    n = 0;
    while (rst_n !== 1'b1 && n < ACCEPT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1)
      report_timeout("reset release");
    for (i = 0; i < 20; i++)
    begin
      check_value("reset", "tx", 1, tx);
      check_value("reset", "cmd_rdy", 1, cmd_rdy);
      check_value("reset", "read_rdy", 0, read_rdy);
      check_value("reset", "read_err", 0, read_err);
      @(negedge clk);
    end

    for (i = 0; i < n_tests; i++)
    begin
      cur_name = t_name[i];
      send_cmd(t_name[i], t_cmd[i]);
      if (t_chain[i])
      begin
        cmd_in  = t_next[i];
        cmd_vld = 1'b1;
      end
      if (t_cmd[i][`UART_OP_BIT] == OP_WRITE)
        write_phase(t_name[i], t_cmd[i]);
      else
        read_phase(t_name[i], t_cmd[i], t_mode[i], t_rsp[i]);
      if (t_chain[i])
      begin
        // Held command was taken right after the read result.
        check_value(t_name[i], "cmd_rdy with held command", 0, cmd_rdy);
        cmd_vld = 1'b0;
        write_phase(t_name[i], t_next[i]);
      end
      idle_check(t_name[i]);
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 4
)
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released away from the active edge.
  end

endmodule

`default_nettype wire

// File: source/uart_cmd_bridge.sv
`default_nettype none
`timescale 1ns/100ps

`include "uart_bridge_config.svh"

module uart_cmd_bridge
  import uart_bridge_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`UART_CMD_WIDTH-1:0] cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       tx,
  output logic                       cmd_rdy,
  output uart_byte_t                 read_data,
  output logic                       read_rdy,
  output logic                       read_err
);

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       tx_done;
  uart_byte_t rx_byte;
  logic       rx_vld;
  logic       rx_parity_err;
  logic       rx_frame_err;
  logic       rx_active;

  uart_cmd_ctrl ctrl0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_start      (tx_start),
    .tx_byte       (tx_byte),
    .tx_busy       (tx_busy),
    .tx_done       (tx_done),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .rx_active     (rx_active),
    .read_data     (read_data),
    .read_rdy      (read_rdy),
    .read_err      (read_err)
  );

  uart_tx_frame #(
    .BAUD_DIV (`UART_BAUD_DIV)
  ) tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  // Receiver runs all the time, the controller filters by state.
  uart_rx_frame #(
    .BAUD_DIV (`UART_BAUD_DIV)
  ) rx0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_vld        (rx_vld),
    .rx_parity_err (rx_parity_err),
    .rx_frame_err  (rx_frame_err),
    .rx_active     (rx_active)
  );

endmodule

`default_nettype wire

// File: source/uart_cmd_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "uart_bridge_config.svh"

module uart_cmd_ctrl
  import uart_bridge_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`UART_CMD_WIDTH-1:0] cmd_in,
  input  logic                       cmd_vld,
  output logic                       cmd_rdy,
  output logic                       tx_start,
  output uart_byte_t                 tx_byte,
  input  logic                       tx_busy,
  input  logic                       tx_done,
  input  uart_byte_t                 rx_byte,
  input  logic                       rx_vld,
  input  logic                       rx_parity_err,
  input  logic                       rx_frame_err,
  input  logic                       rx_active,
  output uart_byte_t                 read_data,
  output logic                       read_rdy,
  output logic                       read_err
);

  localparam int TICK_W = $clog2(`UART_BAUD_DIV);
  localparam int BITS_W = $clog2(`UART_RSP_TIMEOUT_BITS + `UART_GAP_BITS + 1);

  ctrl_state_e                state;
  ctrl_state_e                state_nxt;
  logic [`UART_CMD_WIDTH-1:0] cmd_q;
  cmd_op_e                    op;
  logic [TICK_W-1:0]          tick_cnt;
  logic [BITS_W-1:0]          bits_left;
  logic                       bit_tick;
  logic                       count_end;
  logic                       accept;
  logic                       rsp_clean;
  logic                       rsp_ok;

  assign accept    = cmd_vld && cmd_rdy;
  assign op        = cmd_op_e'(cmd_q[`UART_OP_BIT]);
  assign bit_tick  = (tick_cnt == TICK_W'(`UART_BAUD_DIV - 1));
  assign count_end = bit_tick && (bits_left == BITS_W'(1));
  assign rsp_clean = rx_vld && !rx_parity_err && !rx_frame_err;

  always_comb
  begin
    state_nxt = state;
    case (state)
      IDLE:      if (accept) state_nxt = SEND_ADDR;
      SEND_ADDR: if (!tx_busy) state_nxt = WAIT_ADDR;
      WAIT_ADDR: if (tx_done) state_nxt = (op == OP_WRITE) ? GAP : WAIT_RSP;
      GAP:       if (count_end) state_nxt = SEND_DATA;
      SEND_DATA: if (!tx_busy) state_nxt = WAIT_DATA;
      WAIT_DATA: if (tx_done) state_nxt = IDLE;
      WAIT_RSP:  if (rx_vld || (count_end && !rx_active)) state_nxt = RSP_DONE;
      RSP_DONE:  state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      cmd_rdy <= 1'b1;
    end
    else
    begin
      state   <= state_nxt;
      cmd_rdy <= (state_nxt == IDLE);
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
  end

  // Bit period counter, shared by the write gap and the response timeout.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt  <= '0;
      bits_left <= '0;
    end
    else if (state == WAIT_ADDR && tx_done)
    begin
      tick_cnt  <= '0;
      bits_left <= (op == OP_WRITE) ? BITS_W'(`UART_GAP_BITS)
                                    : BITS_W'(`UART_RSP_TIMEOUT_BITS);
    end
    else if (state == GAP || (state == WAIT_RSP && !rx_active))  // Held once a start edge is seen.
    begin
      if (bit_tick)
      begin
        tick_cnt  <= '0;
        bits_left <= bits_left - 1'b1;
      end
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rsp_ok <= 1'b0;
    else if (state == WAIT_RSP)
      rsp_ok <= rsp_clean;  // Low on timeout.
  end

  always_ff @(posedge clk)
  begin
    if (state == WAIT_RSP && rsp_clean)
      read_data <= rx_byte;
  end

  assign tx_start = (state == SEND_ADDR || state == SEND_DATA) && !tx_busy;
  assign tx_byte  = (state == SEND_DATA) ? cmd_q[`UART_ADDR_LSB-1:0]
                  : {cmd_q[`UART_OP_BIT], cmd_q[`UART_ADDR_MSB:`UART_ADDR_LSB]};
  assign read_rdy = (state == RSP_DONE) && rsp_ok;
  assign read_err = (state == RSP_DONE) && !rsp_ok;

  a_rdy_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy == (state == IDLE));

  // A result lasts one cycle and frees the host side right after.
  a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (read_rdy || read_err) |=> cmd_rdy && !read_rdy && !read_err);

endmodule

`default_nettype wire

// File: uart/uart_rx_frame.sv
`default_nettype none
`timescale 1ns/100ps

`include "uart_bridge_config.svh"

module uart_rx_frame
  import uart_bridge_pkg::*;
#(
  parameter int BAUD_DIV = `UART_BAUD_DIV
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output uart_byte_t rx_byte,
  output logic       rx_vld,
  output logic       rx_parity_err,
  output logic       rx_frame_err,
  output logic       rx_active
);

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam int HALF  = BAUD_DIV / 2;
  localparam logic [3:0] BIT_START  = 4'd0;
  localparam logic [3:0] BIT_PARITY = 4'd9;
  localparam logic [3:0] BIT_STOP   = 4'd10;

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_sync_d;
  logic             fall_edge;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic             mid_bit;

  assign fall_edge = rx_sync_d && !rx_sync;
  assign mid_bit   = (baud_cnt == CNT_W'(HALF));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_sync_d <= 1'b1;
    end
    else
    begin
      rx_meta   <= rx;
      rx_sync   <= rx_meta;
      rx_sync_d <= rx_sync;  // Edge detect.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_active <= 1'b0;
      rx_vld    <= 1'b0;
      baud_cnt  <= '0;
      bit_idx   <= '0;
    end
    else
    begin
      rx_vld <= 1'b0;
      if (!rx_active)
      begin
        if (fall_edge)
        begin
          rx_active <= 1'b1;
          baud_cnt  <= '0;
          bit_idx   <= BIT_START;
        end
      end
      else if (mid_bit && bit_idx == BIT_START && rx_sync)
        rx_active <= 1'b0;  // Glitch, back to idle.
      else if (mid_bit && bit_idx == BIT_STOP)
      begin
        // Frame ends at the stop sample so a following start edge is not missed.
        rx_active <= 1'b0;
        rx_vld    <= 1'b1;
      end
      else if (baud_cnt == CNT_W'(BAUD_DIV - 1))
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_active && mid_bit)
    begin
      case (bit_idx)
        BIT_START:  ;
        BIT_PARITY: rx_parity_err <= rx_sync ^ (^rx_byte);
        BIT_STOP:   rx_frame_err  <= !rx_sync;
        default:    rx_byte       <= {rx_sync, rx_byte[7:1]};  // LSB first.
      endcase
    end
  end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_vld |=> !rx_vld);

endmodule

`default_nettype wire

// File: uart/uart_tx_frame.sv
`default_nettype none
`timescale 1ns/100ps

`include "uart_bridge_config.svh"

module uart_tx_frame
  import uart_bridge_pkg::*;
#(
  parameter int BAUD_DIV = `UART_BAUD_DIV
)
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_byte,
  output logic       tx,
  output logic       tx_busy,
  output logic       tx_done
);

  localparam int CNT_W = $clog2(BAUD_DIV);
  localparam logic [3:0] BIT_STOP = 4'd10;

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [9:0]       frame_q;  // Stop, parity, data.
  logic             bit_end;

  assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign tx_done = tx_busy && bit_end && (bit_idx == BIT_STOP);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (tx_start)
    begin
      tx       <= 1'b0;  // Start bit.
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (tx_busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        if (bit_idx == BIT_STOP)
          tx_busy <= 1'b0;
        else
        begin
          tx      <= frame_q[0];
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // Even parity makes the count of ones over data and parity even.
  always_ff @(posedge clk)
  begin
    if (tx_start)
      frame_q <= {1'b1, ^tx_byte, tx_byte};
    else if (tx_busy && bit_end)
      frame_q <= {1'b1, frame_q[9:1]};
  end

  // The controller must wait for the line to free up.
  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// File: common/uart_bridge_pkg.sv
`default_nettype none

package uart_bridge_pkg;

  // Payload of one UART frame.
  typedef logic [7:0] uart_byte_t;

  // Operation bit of the command word.
  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // Command controller states.
  typedef enum logic [3:0]
  {
    IDLE      = 4'd0,
    SEND_ADDR = 4'd1,
    WAIT_ADDR = 4'd2,
    GAP       = 4'd3,  // Line idle between write frames.
    SEND_DATA = 4'd4,
    WAIT_DATA = 4'd5,
    WAIT_RSP  = 4'd6,  // Read response or timeout.
    RSP_DONE  = 4'd7
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: common/uart_bridge_config.svh
`ifndef UART_BRIDGE_CONFIG_SVH
`define UART_BRIDGE_CONFIG_SVH

// Clock cycles per UART bit.
`define UART_BAUD_DIV          434

// Idle bit times between address and data frames of a write.
`define UART_GAP_BITS          2

// Bit times allowed for a read response to start.
`define UART_RSP_TIMEOUT_BITS  24

// Command word layout.
`define UART_CMD_WIDTH         16
`define UART_OP_BIT            15
`define UART_ADDR_MSB          14
`define UART_ADDR_LSB          8

`endif
